// File: common/fix_session_pkg.sv
/*
 * shared sizes, vector types, enums and structs of the FIX session engine
 * event codes, session states, action kinds and the stage payloads
 */
package fix_session_pkg;

	localparam int NUM_HOST   = 8;
	localparam int HOST_W     = 3;
	localparam int COMP_ID_W  = 64;	// eight ASCII characters
	localparam int COMP_LEN_W = 4;

	typedef logic [HOST_W-1:0]     host_t;
	typedef logic [COMP_ID_W-1:0]  comp_id_t;
	typedef logic [COMP_LEN_W-1:0] comp_len_t;

	// message type as reported by the receive path
	typedef enum logic [3:0] {
		MT_LOGON,
		MT_LOGOUT,
		MT_HEARTBEAT,
		MT_RESEND_REQ,
		MT_GAP_FILL,
		MT_SEQ_RESET,
		MT_APP
	} msg_type_e;

	typedef enum logic [2:0] {
		VAL_OK,
		VAL_GARBLED,
		VAL_SEQ_HIGH,
		VAL_SEQ_LOW,
		VAL_INVALID
	} validity_e;

	// who raised the event
	typedef enum logic [2:0] {
		SRC_MSG,
		SRC_CONNECT,
		SRC_TIMEOUT,
		SRC_END,
		SRC_RESEND_DONE
	} src_e;

	typedef enum logic [2:0] {
		S_DISCONNECTED,
		S_LOGON_SENT,
		S_NORMAL,
		S_HB_SENT,
		S_RESEND_REQ,
		S_RESEND_REQ_LOGOUT,
		S_LOGOUT_SENT
	} sess_state_e;

	// decoded event classes, _HIGH means sequence number too high
	typedef enum logic [3:0] {
		EV_CONNECT,
		EV_TIMEOUT,
		EV_END,
		EV_RESEND_DONE,
		EV_FATAL,
		EV_GARBLED,
		EV_LOGON,
		EV_LOGON_HIGH,
		EV_LOGOUT,
		EV_LOGOUT_HIGH,
		EV_HEARTBEAT,
		EV_RESEND_REQ,
		EV_SEQ_FILL,	// gap fill or sequence reset
		EV_SEQ_FILL_HIGH,
		EV_MSG,
		EV_MSG_HIGH
	} sess_event_e;

	typedef enum logic [2:0] {
		ACT_NONE,
		ACT_SEND_LOGON,
		ACT_SEND_LOGOUT,
		ACT_SEND_HEARTBEAT,
		ACT_SEND_RESEND_REQ,
		ACT_DISCONNECT,
		ACT_SEQ_UPDATE,
		ACT_IGNORE
	} act_kind_e;

	typedef struct packed {
		src_e      src;
		host_t     host;
		msg_type_e msg_type;
		validity_e validity;
	} sess_in_t;

	typedef struct packed {
		sess_event_e ev;
		host_t       host;
	} sess_dec_t;

	typedef struct packed {
		act_kind_e kind;
		host_t     host;
	} sess_act_t;

	// action leaving the engine towards builder, TCP engine and counters
	typedef struct packed {
		act_kind_e kind;
		host_t     host;
		comp_id_t  comp_id;
		comp_len_t comp_len;
	} act_out_t;

endpackage

// File: session/session_event_decode.sv
/*
 * input event register with valid/ready handshake
 * classifies each event into a session event code
 */
`timescale 1ns/1ps

module session_event_decode import fix_session_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      evt_valid_i,
	input  sess_in_t  evt_i,
	output logic      evt_ready_o,
	input  logic      stall_i,
	output logic      dec_valid_o,
	output sess_dec_t dec_o
);

	logic      run_q;	// low during reset and the cycle of it
	logic      dec_valid_q;
	sess_dec_t dec_q;

	function automatic sess_event_e classify(input sess_in_t e);
		logic hi;
		hi = (e.validity == VAL_SEQ_HIGH);
		case (e.src)
		SRC_CONNECT:     classify = EV_CONNECT;
		SRC_TIMEOUT:     classify = EV_TIMEOUT;
		SRC_END:         classify = EV_END;
		SRC_RESEND_DONE: classify = EV_RESEND_DONE;
		SRC_MSG: begin
			if (e.validity == VAL_GARBLED)
				classify = EV_GARBLED;
			else if (e.validity != VAL_OK && !hi)
				classify = EV_FATAL;	// seq low, invalid, unknown codes
			else begin
				case (e.msg_type)
				MT_LOGON:     classify = hi ? EV_LOGON_HIGH : EV_LOGON;
				MT_LOGOUT:    classify = hi ? EV_LOGOUT_HIGH : EV_LOGOUT;
				MT_HEARTBEAT: classify = hi ? EV_MSG_HIGH : EV_HEARTBEAT;
				MT_RESEND_REQ: classify = hi ? EV_MSG_HIGH : EV_RESEND_REQ;
				MT_GAP_FILL,
				MT_SEQ_RESET: classify = hi ? EV_SEQ_FILL_HIGH : EV_SEQ_FILL;
				default:      classify = hi ? EV_MSG_HIGH : EV_MSG;
				endcase
			end
		end
		default:         classify = EV_GARBLED;	// unknown source is ignored later
		endcase
	endfunction

	assign evt_ready_o = run_q & (~dec_valid_q | ~stall_i);
	assign dec_valid_o = dec_valid_q;
	assign dec_o       = dec_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_q       <= 1'b0;
			dec_valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (evt_ready_o)
				dec_valid_q <= evt_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (evt_ready_o && evt_valid_i) begin
			dec_q.ev   <= classify(evt_i);
			dec_q.host <= evt_i.host;
		end
	end

	// the source must hold a waiting event
	a_evt_stable: assert property (@(posedge clk) disable iff (rst)
		evt_valid_i && !evt_ready_o |=> $stable(evt_i));

endmodule

// File: session/session_exec.sv
/*
 * per-host session state table and FIX session transition rules
 * registers one action per event, ACT_NONE is dropped
 */
`timescale 1ns/1ps

module session_exec import fix_session_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      dec_valid_i,
	input  sess_dec_t dec_i,
	output logic      stall_o,
	input  logic      act_ready_i,
	output logic      act_valid_o,
	output sess_act_t act_o
);

	sess_state_e state_tbl [NUM_HOST];
	sess_state_e cur_state;
	sess_state_e nxt_state;
	act_kind_e   nxt_kind;
	logic        act_valid_q;
	sess_act_t   act_q;
	logic        take;

	assign stall_o     = act_valid_q & ~act_ready_i;
	assign take        = dec_valid_i & ~stall_o;
	assign act_valid_o = act_valid_q;
	assign act_o       = act_q;

	always_comb begin
		cur_state = state_tbl[dec_i.host];
		nxt_state = cur_state;
		nxt_kind  = ACT_NONE;
		case (dec_i.ev)
		EV_FATAL: begin
			nxt_kind  = ACT_DISCONNECT;
			nxt_state = S_DISCONNECTED;
		end
		EV_CONNECT: begin
			nxt_kind  = ACT_SEND_LOGON;
			nxt_state = S_LOGON_SENT;
		end
		EV_END: begin
			nxt_kind  = ACT_SEND_LOGOUT;
			nxt_state = S_LOGOUT_SENT;
		end
		EV_TIMEOUT: begin
			if (cur_state inside {S_LOGON_SENT, S_HB_SENT, S_LOGOUT_SENT}) begin
				nxt_kind  = ACT_DISCONNECT;
				nxt_state = S_DISCONNECTED;
			end else if (cur_state != S_DISCONNECTED) begin
				nxt_kind  = ACT_SEND_HEARTBEAT;
				nxt_state = S_HB_SENT;
			end
		end
		EV_RESEND_DONE: begin
			if (cur_state == S_RESEND_REQ)
				nxt_state = S_NORMAL;
			else if (cur_state == S_RESEND_REQ_LOGOUT) begin
				nxt_kind  = ACT_SEND_LOGOUT;
				nxt_state = S_LOGOUT_SENT;
			end
		end
		default: begin	// received messages
			if (cur_state == S_DISCONNECTED || dec_i.ev == EV_GARBLED)
				nxt_kind = ACT_IGNORE;
			else begin
				case (cur_state)
				S_LOGON_SENT: begin
					if (dec_i.ev == EV_LOGON)
						nxt_state = S_NORMAL;
					else if (dec_i.ev == EV_LOGON_HIGH) begin
						nxt_kind  = ACT_SEND_RESEND_REQ;
						nxt_state = S_RESEND_REQ;
					end else begin
						nxt_kind  = ACT_DISCONNECT;
						nxt_state = S_DISCONNECTED;
					end
				end
				S_NORMAL, S_HB_SENT: begin
					case (dec_i.ev)
					EV_LOGOUT: begin
						nxt_kind  = ACT_SEND_LOGOUT;
						nxt_state = S_DISCONNECTED;
					end
					EV_LOGOUT_HIGH: begin
						nxt_kind  = ACT_SEND_RESEND_REQ;
						nxt_state = S_RESEND_REQ_LOGOUT;
					end
					EV_LOGON_HIGH, EV_SEQ_FILL_HIGH, EV_MSG_HIGH: begin
						nxt_kind  = ACT_SEND_RESEND_REQ;
						nxt_state = S_RESEND_REQ;
					end
					EV_HEARTBEAT: begin
						nxt_kind  = ACT_SEND_HEARTBEAT;
						nxt_state = S_HB_SENT;
					end
					EV_RESEND_REQ: nxt_kind = ACT_IGNORE;	// serving resend not done here
					default:       nxt_state = S_NORMAL;	// peer alive again
					endcase
				end
				S_RESEND_REQ, S_RESEND_REQ_LOGOUT: begin
					if (dec_i.ev inside {EV_LOGON_HIGH, EV_LOGOUT_HIGH, EV_MSG_HIGH})
						nxt_kind = ACT_SEND_RESEND_REQ;
					else if (dec_i.ev inside {EV_SEQ_FILL, EV_SEQ_FILL_HIGH})
						nxt_kind = ACT_SEQ_UPDATE;
				end
				default: begin	// logout sent
					nxt_kind  = ACT_DISCONNECT;
					nxt_state = S_DISCONNECTED;
				end
				endcase
			end
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			act_valid_q <= 1'b0;
			for (int i = 0; i < NUM_HOST; i++)
				state_tbl[i] <= S_DISCONNECTED;
		end else begin
			if (!stall_o)
				act_valid_q <= take & (nxt_kind != ACT_NONE);
			if (take)
				state_tbl[dec_i.host] <= nxt_state;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			act_q.kind <= nxt_kind;
			act_q.host <= dec_i.host;
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		take |=> state_tbl[$past(dec_i.host)] inside {S_DISCONNECTED, S_LOGON_SENT,
			S_NORMAL, S_HB_SENT, S_RESEND_REQ, S_RESEND_REQ_LOGOUT, S_LOGOUT_SENT});

endmodule

// File: session/session_action_out.sv
/*
 * action result register with valid/ack handshake
 * attaches the target CompID and its length
 */
`timescale 1ns/1ps

module session_action_out import fix_session_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      act_valid_i,
	input  sess_act_t act_i,
	output logic      act_ready_o,
	output host_t     cid_host_o,
	input  comp_id_t  cid_i,
	input  comp_len_t cid_len_i,
	output logic      act_valid_o,
	output act_out_t  act_o,
	input  logic      act_ack_i
);

	logic     valid_q;
	act_out_t out_q;
	logic     load;

	assign act_ready_o = ~valid_q | act_ack_i;
	assign load        = act_valid_i & act_ready_o;
	assign cid_host_o  = act_i.host;	// table lookup is combinational
	assign act_valid_o = valid_q;
	assign act_o       = out_q;

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else if (load)
			valid_q <= 1'b1;
		else if (act_ack_i)
			valid_q <= 1'b0;
	end

	// payload moves only on a new load
	always_ff @(posedge clk) begin
		if (load) begin
			out_q.kind     <= act_i.kind;
			out_q.host     <= act_i.host;
			out_q.comp_id  <= cid_i;
			out_q.comp_len <= cid_len_i;
		end
	end

	a_act_hold: assert property (@(posedge clk) disable iff (rst)
		act_valid_o && !act_ack_i |=> act_valid_o && $stable(act_o));

endmodule

// File: verilog/comp_id_table.sv
/*
 * per-host target CompID and length table
 * Wishbone classic slave for loading, combinational lookup port
 */
`timescale 1ns/1ps

module comp_id_table import fix_session_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [5:0]  wb_adr_i,	// host in [5:3], word in [2:0]
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,
	input  host_t       rd_host_i,
	output comp_id_t    rd_id_o,
	output comp_len_t   rd_len_o
);

	comp_id_t  id_tbl  [NUM_HOST];
	comp_len_t len_tbl [NUM_HOST];
	host_t     wb_host;
	logic      wb_req;
	logic      ack_q;

	assign wb_host = host_t'(wb_adr_i[5:3]);
	assign wb_req  = wb_cyc_i & wb_stb_i & ~ack_q;
	assign wb_ack_o = ack_q;

	assign rd_id_o  = id_tbl[rd_host_i];
	assign rd_len_o = len_tbl[rd_host_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q    <= 1'b0;
			wb_dat_o <= '0;
			for (int i = 0; i < NUM_HOST; i++) begin
				id_tbl[i]  <= '0;
				len_tbl[i] <= '0;
			end
		end else begin
			ack_q <= wb_req;	// one ack per strobe
			if (wb_req && wb_we_i) begin
				case (wb_adr_i[2:0])
				3'd0: id_tbl[wb_host][31:0]  <= wb_dat_i;
				3'd1: id_tbl[wb_host][63:32] <= wb_dat_i;
				3'd2: len_tbl[wb_host]       <= wb_dat_i[COMP_LEN_W-1:0];
				default: ;
				endcase
			end
			if (wb_req && !wb_we_i) begin
				case (wb_adr_i[2:0])
				3'd0:    wb_dat_o <= id_tbl[wb_host][31:0];
				3'd1:    wb_dat_o <= id_tbl[wb_host][63:32];
				3'd2:    wb_dat_o <= {{(32-COMP_LEN_W){1'b0}}, len_tbl[wb_host]};
				default: wb_dat_o <= '0;
				endcase
			end
		end
	end

endmodule

// File: verilog/fix_session_top.sv
/*
 * FIX session engine top level
 * decode, execute and action stages plus the CompID table
 */
`timescale 1ns/1ps

module fix_session_top import fix_session_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        evt_valid_i,
	input  sess_in_t    evt_i,
	output logic        evt_ready_o,
	output logic        act_valid_o,
	output act_out_t    act_o,
	input  logic        act_ack_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [5:0]  wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o
);

	logic      dec_valid;
	sess_dec_t dec;
	logic      exec_stall;
	logic      act_valid;
	sess_act_t act;
	logic      act_ready;
	host_t     cid_host;
	comp_id_t  cid_id;
	comp_len_t cid_len;

	session_event_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.evt_valid_i (evt_valid_i),
		.evt_i       (evt_i),
		.evt_ready_o (evt_ready_o),
		.stall_i     (exec_stall),
		.dec_valid_o (dec_valid),
		.dec_o       (dec)
	);

	session_exec u_exec (
		.clk         (clk),
		.rst         (rst),
		.dec_valid_i (dec_valid),
		.dec_i       (dec),
		.stall_o     (exec_stall),
		.act_ready_i (act_ready),
		.act_valid_o (act_valid),
		.act_o       (act)
	);

	session_action_out u_action (
		.clk         (clk),
		.rst         (rst),
		.act_valid_i (act_valid),
		.act_i       (act),
		.act_ready_o (act_ready),
		.cid_host_o  (cid_host),
		.cid_i       (cid_id),
		.cid_len_i   (cid_len),
		.act_valid_o (act_valid_o),
		.act_o       (act_o),
		.act_ack_i   (act_ack_i)
	);

	comp_id_table u_comp_id (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.rd_host_i (cid_host),
		.rd_id_o   (cid_id),
		.rd_len_o  (cid_len)
	);

endmodule

// File: tests/tb_fix_session.sv
/*
 * testbench for the FIX session engine
 * Wishbone CompID loader and readback, stimulus table with expected actions,
 * action checker with random ack delay, cycle watchdog
 */
`timescale 1ns/1ps

module tb_fix_session import fix_session_pkg::*; ();

	localparam logic [31:0] SEED = 32'h3f163b8b;

	typedef struct packed {
		sess_in_t  evt;
		act_kind_e kind;	// ACT_NONE when no action is expected
	} stim_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        evt_valid_i;
	sess_in_t    evt_i;
	logic        evt_ready_o;
	logic        act_valid_o;
	act_out_t    act_o;
	logic        act_ack_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [5:0]  wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;

	stim_t tbl [$];
	int    exp_idx [$];	// table entries that must produce an action
	int    got_cnt   = 0;
	int    val_err   = 0;
	int    other_err = 0;
	int    cycle_cnt = 0;
	int    limit     = 0;

	fix_session_top u_fix_session_top (.*);

	always #2 clk = ~clk;

	// ASCII TGT<n>-H<A+n><a+n> differs per host in both words
	function automatic comp_id_t comp_id_of(input host_t h);
		return {8'h54, 8'h47, 8'h54, 8'h30 + 8'(h), 8'h2D, 8'h48, 8'h41 + 8'(h), 8'h61 + 8'(h)};
	endfunction

	function automatic comp_len_t comp_len_of(input host_t h);
		return comp_len_t'(h + 1);
	endfunction

	task automatic add_event(input src_e src, input int h, input msg_type_e mt,
		input validity_e v, input act_kind_e k);
		stim_t s;
		s.evt.src      = src;
		s.evt.host     = host_t'(h);
		s.evt.msg_type = mt;
		s.evt.validity = v;
		s.kind         = k;
		tbl.push_back(s);
		if (k != ACT_NONE)
			exp_idx.push_back(tbl.size() - 1);
	endtask

	task automatic build_table();
		for (int h = 0; h < NUM_HOST; h++)
			add_event(SRC_CONNECT, h, MT_APP, VAL_OK, ACT_SEND_LOGON);
		// host 0 logon, heartbeat, timeout in hb_sent
		add_event(SRC_MSG, 0, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_MSG, 0, MT_HEARTBEAT, VAL_OK, ACT_SEND_HEARTBEAT);
		add_event(SRC_TIMEOUT, 0, MT_APP, VAL_OK, ACT_DISCONNECT);
		// host 1 sequence recovery
		add_event(SRC_MSG, 1, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_MSG, 1, MT_APP, VAL_SEQ_HIGH, ACT_SEND_RESEND_REQ);
		add_event(SRC_MSG, 1, MT_GAP_FILL, VAL_OK, ACT_SEQ_UPDATE);
		add_event(SRC_MSG, 1, MT_SEQ_RESET, VAL_OK, ACT_SEQ_UPDATE);
		add_event(SRC_RESEND_DONE, 1, MT_APP, VAL_OK, ACT_NONE);
		add_event(SRC_TIMEOUT, 1, MT_APP, VAL_OK, ACT_SEND_HEARTBEAT);	// back in normal
		// logout paths on hosts 2 and 3
		add_event(SRC_MSG, 2, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_MSG, 2, MT_LOGOUT, VAL_SEQ_HIGH, ACT_SEND_RESEND_REQ);
		add_event(SRC_RESEND_DONE, 2, MT_APP, VAL_OK, ACT_SEND_LOGOUT);
		add_event(SRC_MSG, 3, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_END, 3, MT_APP, VAL_OK, ACT_SEND_LOGOUT);
		add_event(SRC_MSG, 3, MT_LOGOUT, VAL_OK, ACT_DISCONNECT);
		// errors and noise on hosts 4 and 5
		add_event(SRC_MSG, 4, MT_APP, VAL_GARBLED, ACT_IGNORE);
		add_event(SRC_MSG, 4, MT_APP, VAL_SEQ_LOW, ACT_DISCONNECT);
		add_event(SRC_MSG, 4, MT_HEARTBEAT, VAL_OK, ACT_IGNORE);
		add_event(SRC_MSG, 5, MT_LOGON, VAL_SEQ_HIGH, ACT_SEND_RESEND_REQ);
		add_event(SRC_MSG, 5, MT_APP, VAL_INVALID, ACT_DISCONNECT);
		// hosts 6 and 7 interleaved
		add_event(SRC_MSG, 6, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_MSG, 7, MT_LOGON, VAL_OK, ACT_NONE);
		add_event(SRC_MSG, 6, MT_HEARTBEAT, VAL_OK, ACT_SEND_HEARTBEAT);
		add_event(SRC_MSG, 7, MT_APP, VAL_SEQ_HIGH, ACT_SEND_RESEND_REQ);
		add_event(SRC_TIMEOUT, 6, MT_APP, VAL_OK, ACT_DISCONNECT);
		add_event(SRC_MSG, 7, MT_GAP_FILL, VAL_OK, ACT_SEQ_UPDATE);
		add_event(SRC_MSG, 6, MT_APP, VAL_OK, ACT_IGNORE);
		add_event(SRC_RESEND_DONE, 7, MT_APP, VAL_OK, ACT_NONE);
		add_event(SRC_CONNECT, 6, MT_APP, VAL_OK, ACT_SEND_LOGON);
		add_event(SRC_TIMEOUT, 7, MT_APP, VAL_OK, ACT_SEND_HEARTBEAT);
		add_event(SRC_END, 6, MT_APP, VAL_OK, ACT_SEND_LOGOUT);
		add_event(SRC_TIMEOUT, 7, MT_APP, VAL_OK, ACT_DISCONNECT);
	endtask

	// one classic cycle that returns after the ack edge plus one idle cycle
	task automatic wb_access(input logic we, input int h, input int word,
		input logic [31:0] wdata, output logic [31:0] rdata);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= 6'(h * 8 + word);
		wb_dat_i <= wdata;
		do @(posedge clk); while (!wb_ack_o);
		rdata = wb_dat_o;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		@(posedge clk);
	endtask

	function automatic logic [31:0] wb_word_of(input int h, input int word);
		comp_id_t id;
		id = comp_id_of(host_t'(h));
		if (word == 0)
			return id[31:0];
		else if (word == 1)
			return id[63:32];
		return {28'h0, comp_len_of(host_t'(h))};
	endfunction

	task automatic check_action(input act_out_t a);
		stim_t s;
		host_t h;
		if (got_cnt >= exp_idx.size()) begin
			$display("unexpected extra action of kind %h for host %0d", a.kind, a.host);
			other_err++;
		end else begin
			s = tbl[exp_idx[got_cnt]];
			h = s.evt.host;
			if (a.kind != s.kind) begin
				$display("Fail act_o.kind (entry %0d): got %h expected %h",
					exp_idx[got_cnt], a.kind, s.kind);
				val_err++;
			end
			if (a.host != h) begin
				$display("Fail act_o.host (entry %0d): got %h expected %h",
					exp_idx[got_cnt], a.host, h);
				val_err++;
			end
			if (a.comp_id != comp_id_of(h)) begin
				$display("Fail act_o.comp_id (entry %0d): got %h expected %h",
					exp_idx[got_cnt], a.comp_id, comp_id_of(h));
				val_err++;
			end
			if (a.comp_len != comp_len_of(h)) begin
				$display("Fail act_o.comp_len (entry %0d): got %h expected %h",
					exp_idx[got_cnt], a.comp_len, comp_len_of(h));
				val_err++;
			end
		end
		got_cnt++;
	endtask

	task automatic report_and_finish();
		$display("errors: %0d value mismatches, %0d other failures, %0d of %0d actions seen",
			val_err, other_err, got_cnt, exp_idx.size());
		if (val_err == 0 && other_err == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	// watchdog limit of about 12 cycles per table entry plus loader and drain
	always @(posedge clk) begin
		cycle_cnt++;
		if (limit > 0 && cycle_cnt >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			other_err++;
			report_and_finish();
		end
	end

	// action consumer acks after a random 0 to 3 cycle gap
	initial begin
		int gap;
		void'($urandom(SEED));
		act_ack_i <= 1'b0;
		forever begin
			@(posedge clk);
			if (!rst && act_valid_o) begin
				gap = $urandom % 4;
				repeat (gap) @(posedge clk);
				act_ack_i <= 1'b1;
				@(posedge clk);	// taken on this edge
				check_action(act_o);
				act_ack_i <= 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] rd;
		int          idle;
		rst         <= 1'b1;
		evt_valid_i <= 1'b0;
		evt_i       <= '0;
		wb_cyc_i    <= 1'b0;
		wb_stb_i    <= 1'b0;
		wb_we_i     <= 1'b0;
		wb_adr_i    <= '0;
		wb_dat_i    <= '0;
		build_table();
		limit = tbl.size() * 12 + 200;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		for (int h = 0; h < NUM_HOST; h++)
			for (int w = 0; w < 3; w++)
				wb_access(1'b1, h, w, wb_word_of(h, w), rd);
		for (int h = 0; h < NUM_HOST; h++) begin
			for (int w = 0; w < 3; w++) begin
				wb_access(1'b0, h, w, 32'h0, rd);
				if (rd !== wb_word_of(h, w)) begin
					$display("Fail wb_dat_o (host %0d word %0d): got %h expected %h",
						h, w, rd, wb_word_of(h, w));
					val_err++;
				end
			end
		end

		// events go back to back and are held until accepted
		for (int i = 0; i < tbl.size(); i++) begin
			evt_valid_i <= 1'b1;
			evt_i       <= tbl[i].evt;
			do @(posedge clk); while (!evt_ready_o);
		end
		evt_valid_i <= 1'b0;

		idle = 0;
		while (got_cnt < exp_idx.size() && idle < 40) begin
			@(posedge clk);
			if (act_valid_o)
				idle = 0;
			else
				idle++;
		end
		repeat (20) @(posedge clk);	// room for stray extra actions
		if (got_cnt < exp_idx.size()) begin
			$display("%0d expected actions never arrived", exp_idx.size() - got_cnt);
			other_err++;
		end
		report_and_finish();
	end

endmodule

// File: verilog.f
common/fix_session_pkg.sv
session/session_event_decode.sv
session/session_exec.sv
session/session_action_out.sv
verilog/comp_id_table.sv
verilog/fix_session_top.sv
tests/tb_fix_session.sv

// File: Bender.yml
package:
  name: fix_session

sources:
  - common/fix_session_pkg.sv
  - session/session_event_decode.sv
  - session/session_exec.sv
  - session/session_action_out.sv
  - verilog/comp_id_table.sv
  - verilog/fix_session_top.sv
  - target: test
    files:
      - tests/tb_fix_session.sv
